// File: build.f
logic/cfg_pkg.sv
logic/nrn_pkg.sv
logic/host_port.sv
logic/config_mem.sv
logic/potential_mem.sv
logic/integrate_stage.sv
logic/fire_stage.sv
logic/nrn_core_top.sv
tb/tb_nrn_core.sv

// File: logic/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

	// --------------------
	// field widths
	// --------------------

	// potentials, masks and input currents share one data width
	localparam int DSIZE = 16;
	// spike address word sent out on the AER bus
	localparam int AER_W = 32;
	// neuron index, enough for 256 neurons
	localparam int IDX_W = 8;

	// --------------------
	// configuration word
	// --------------------

	// one neuron's settings, 66 bits
	// nurn_type 0 is integrate and fire, 1 is relu
	typedef struct packed {
		logic             nurn_type;
		// threshold is th_mask anded with the lfsr when set
		logic             rand_th;
		logic [DSIZE-1:0] th_mask;
		// potential loaded at config time and after a spike
		logic [DSIZE-1:0] rst_pot;
		logic [AER_W-1:0] spike_aer;
	} nrn_cfg_t;

	// host write into the configuration memory
	typedef struct packed {
		logic [IDX_W-1:0] idx;
		nrn_cfg_t         cfg;
	} cfg_wr_t;

endpackage

`default_nettype wire

// File: logic/config_mem.sv
`timescale 1ns/1ps
`default_nettype none

module config_mem #(
	parameter int unsigned NUM_NURNS = 256
) (
	input  wire logic              clk_i,
	input  wire logic              rst_n_i,
	// host write port
	input  wire logic              wr_en_i,
	input  wire cfg_pkg::cfg_wr_t  wr_i,
	// pipelined read port
	input  wire logic              rd_en_i,
	input  wire nrn_pkg::nrn_req_t rd_req_i,
	output logic                   valid_o,
	output nrn_pkg::nrn_req_t      req_o,
	output cfg_pkg::nrn_cfg_t      cfg_o
);
	import cfg_pkg::*;
	import nrn_pkg::*;

	// one configuration word per neuron
	nrn_cfg_t cfg_mem [NUM_NURNS];

	// --------------------
	// host write
	// --------------------

	// writes only arrive while the host port is idle
	always_ff @(posedge clk_i) begin
		if (wr_en_i) begin
			cfg_mem[wr_i.idx] <= wr_i.cfg;
		end
	end

	// --------------------
	// registered read
	// --------------------

	// read enable delayed by one cycle
	// marks the latched word as valid
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= rd_en_i;
		end
	end

	// addressed word latched on the enable
	// request travels alongside for the next stages
	always_ff @(posedge clk_i) begin
		if (rd_en_i) begin
			cfg_o <= cfg_mem[rd_req_i.idx];
			req_o <= rd_req_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/fire_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fire_stage #(
	parameter logic [cfg_pkg::DSIZE-1:0] LFSR_SEED = 16'hACE1
) (
	input  wire logic                 clk_i,
	input  wire logic                 rst_n_i,
	input  wire logic                 valid_i,
	input  wire nrn_pkg::int_item_t   item_i,
	// potential write-back to potential_mem
	output logic                      wb_en_o,
	output logic [cfg_pkg::IDX_W-1:0] wb_idx_o,
	output logic [cfg_pkg::DSIZE-1:0] wb_pot_o,
	// result to the host port
	output logic                      valid_o,
	output nrn_pkg::nrn_res_t         res_o
);
	import cfg_pkg::*;
	import nrn_pkg::*;

	// galois feedback taps, shifting right
	localparam logic [DSIZE-1:0] LFSR_TAPS = 16'hB400;

	logic [DSIZE-1:0] lfsr;
	logic [DSIZE-1:0] lfsr_next;
	logic [DSIZE-1:0] threshold;
	nurn_type_e       ntype;
	logic             if_fire;
	nrn_res_t         res_d;

	// --------------------
	// threshold lfsr
	// --------------------
	assign lfsr_next = {1'b0, lfsr[DSIZE-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);

	// steps once per item, after its value was used
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lfsr <= LFSR_SEED;
		end else if (valid_i) begin
			lfsr <= lfsr_next;
		end
	end

	// --------------------
	// spike decision
	// --------------------
	always_comb begin
		ntype = nurn_type_e'(item_i.cfg.nurn_type);

		// random threshold masks the current lfsr value
		threshold = item_i.cfg.rand_th ? (item_i.cfg.th_mask & lfsr) : item_i.cfg.th_mask;
		if_fire   = (item_i.value >= threshold);

		res_d       = '0;
		res_d.ntype = ntype;
		if (ntype == NT_RELU) begin
			// nonzero activation counts as a fire
			res_d.fired               = (item_i.value != '0);
			res_d.payload.act.act_dst = item_i.cfg.spike_aer[AER_W-1:AER_W-DSIZE];
			res_d.payload.act.act_val = item_i.value;
		end else begin
			res_d.fired = if_fire;
			if (if_fire) begin
				res_d.payload.aer = item_i.cfg.spike_aer;
			end
		end
	end

	// write-back lands on the same edge as the result register
	// relu neurons keep no state
	assign wb_en_o  = valid_i && (ntype == NT_IF);
	assign wb_idx_o = item_i.idx;
	assign wb_pot_o = if_fire ? item_i.cfg.rst_pot : item_i.value;

	// --------------------
	// output register
	// --------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			res_o <= res_d;
		end
	end

endmodule

`default_nettype wire

// File: logic/host_port.sv
`timescale 1ns/1ps
`default_nettype none

module host_port (
	input  wire logic              clk_i,
	input  wire logic              rst_n_i,
	// four-phase host side
	input  wire logic              req_i,
	input  wire nrn_pkg::nrn_req_t req_data_i,
	output logic                   ack_o,
	output nrn_pkg::nrn_res_t      res_o,
	// pipeline side
	output logic                   launch_o,
	output nrn_pkg::nrn_req_t      launch_req_o,
	input  wire logic              res_valid_i,
	input  wire nrn_pkg::nrn_res_t res_i
);
	import nrn_pkg::*;

	// idle waits for req, busy waits for the result, ack waits for req to drop
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_ACK
	} state_t;

	state_t state;

	// --------------------
	// handshake fsm
	// --------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= ST_IDLE;
			launch_o <= 1'b0;
			res_o    <= '0;
		end else begin
			// launch is a single cycle pulse
			launch_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					// new request only seen here, so one item in flight
					if (req_i) begin
						state    <= ST_BUSY;
						launch_o <= 1'b1;
					end
				end
				ST_BUSY: begin
					// hold the result until the next request completes
					if (res_valid_i) begin
						state <= ST_ACK;
						res_o <= res_i;
					end
				end
				ST_ACK: begin
					if (!req_i) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// request payload captured with the launch
	always_ff @(posedge clk_i) begin
		if (state == ST_IDLE && req_i) begin
			launch_req_o <= req_data_i;
		end
	end

	// ack is high for the whole ack state
	assign ack_o = (state == ST_ACK);

endmodule

`default_nettype wire

// File: logic/integrate_stage.sv
`timescale 1ns/1ps
`default_nettype none

module integrate_stage (
	input  wire logic                      clk_i,
	input  wire logic                      rst_n_i,
	input  wire logic                      valid_i,
	input  wire nrn_pkg::nrn_req_t         req_i,
	input  wire cfg_pkg::nrn_cfg_t         cfg_i,
	input  wire logic [cfg_pkg::DSIZE-1:0] pot_i,
	output logic                           valid_o,
	output nrn_pkg::int_item_t             item_o
);
	import cfg_pkg::*;
	import nrn_pkg::*;

	// two guard bits cover both underflow and overflow
	logic [DSIZE+1:0] sum;
	logic [DSIZE-1:0] if_val;
	logic [DSIZE-1:0] relu_val;
	logic [DSIZE-1:0] next_val;

	// --------------------
	// value computation
	// --------------------
	always_comb begin
		// stored potential zero extended, current sign extended
		sum = {2'b00, pot_i} + {{2{req_i.in_cur[DSIZE-1]}}, req_i.in_cur};

		// clamp to 0..65535
		if (sum[DSIZE+1]) begin
			if_val = '0;
		end else if (sum[DSIZE]) begin
			if_val = '1;
		end else begin
			if_val = sum[DSIZE-1:0];
		end

		// relu ignores the stored potential
		relu_val = req_i.in_cur[DSIZE-1] ? '0 : req_i.in_cur;

		next_val = (nurn_type_e'(cfg_i.nurn_type) == NT_RELU) ? relu_val : if_val;
	end

	// --------------------
	// stage register
	// --------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			item_o.idx   <= req_i.idx;
			item_o.cfg   <= cfg_i;
			item_o.value <= next_val;
		end
	end

endmodule

`default_nettype wire

// File: logic/nrn_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module nrn_core_top #(
	parameter int unsigned               NUM_NURNS = 256,
	parameter logic [cfg_pkg::DSIZE-1:0] LFSR_SEED = 16'hACE1
) (
	input  wire logic              clk_i,
	input  wire logic              rst_n_i,
	// configuration write from the host
	input  wire logic              cfg_we_i,
	input  wire cfg_pkg::cfg_wr_t  cfg_wr_i,
	// four-phase request port
	input  wire logic              req_i,
	input  wire nrn_pkg::nrn_req_t req_data_i,
	output logic                   ack_o,
	output nrn_pkg::nrn_res_t      res_o
);
	import cfg_pkg::*;
	import nrn_pkg::*;

	// stage 1 to stage 2
	logic             launch;
	nrn_req_t         launch_req;
	// stage 2 to stage 3
	logic             rd_valid;
	nrn_req_t         rd_req;
	nrn_cfg_t         rd_cfg;
	logic [DSIZE-1:0] rd_pot;
	// stage 3 to stage 4
	logic             int_valid;
	int_item_t        int_item;
	// stage 4 back to the memories and the host port
	logic             wb_en;
	logic [IDX_W-1:0] wb_idx;
	logic [DSIZE-1:0] wb_pot;
	logic             res_valid;
	nrn_res_t         res;

	// --------------------
	// stage 1
	// --------------------
	host_port host_port_inst (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.req_i        (req_i),
		.req_data_i   (req_data_i),
		.ack_o        (ack_o),
		.res_o        (res_o),
		.launch_o     (launch),
		.launch_req_o (launch_req),
		.res_valid_i  (res_valid),
		.res_i        (res)
	);

	// --------------------
	// stage 2
	// --------------------
	config_mem #(
		.NUM_NURNS (NUM_NURNS)
	) config_mem_inst (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.wr_en_i  (cfg_we_i),
		.wr_i     (cfg_wr_i),
		.rd_en_i  (launch),
		.rd_req_i (launch_req),
		.valid_o  (rd_valid),
		.req_o    (rd_req),
		.cfg_o    (rd_cfg)
	);

	potential_mem #(
		.NUM_NURNS (NUM_NURNS)
	) potential_mem_inst (
		.clk_i    (clk_i),
		.cfg_we_i (cfg_we_i),
		.cfg_wr_i (cfg_wr_i),
		.rd_en_i  (launch),
		.rd_idx_i (launch_req.idx),
		.pot_o    (rd_pot),
		.wb_en_i  (wb_en),
		.wb_idx_i (wb_idx),
		.wb_pot_i (wb_pot)
	);

	// --------------------
	// stages 3 and 4
	// --------------------
	integrate_stage integrate_stage_inst (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.valid_i (rd_valid),
		.req_i   (rd_req),
		.cfg_i   (rd_cfg),
		.pot_i   (rd_pot),
		.valid_o (int_valid),
		.item_o  (int_item)
	);

	fire_stage #(
		.LFSR_SEED (LFSR_SEED)
	) fire_stage_inst (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.valid_i  (int_valid),
		.item_i   (int_item),
		.wb_en_o  (wb_en),
		.wb_idx_o (wb_idx),
		.wb_pot_o (wb_pot),
		.valid_o  (res_valid),
		.res_o    (res)
	);

endmodule

`default_nettype wire

// File: logic/nrn_pkg.sv
`default_nettype none

package nrn_pkg;

	// --------------------
	// neuron type
	// --------------------

	typedef enum logic {
		NT_IF   = 1'b0,
		NT_RELU = 1'b1
	} nurn_type_e;

	// --------------------
	// pipeline payloads
	// --------------------

	// integration request from the host
	typedef struct packed {
		logic        [cfg_pkg::IDX_W-1:0] idx;
		logic signed [cfg_pkg::DSIZE-1:0] in_cur;
	} nrn_req_t;

	// integrate stage output
	// value holds the new potential for i&f or the activation for relu
	typedef struct packed {
		logic [cfg_pkg::IDX_W-1:0] idx;
		cfg_pkg::nrn_cfg_t         cfg;
		logic [cfg_pkg::DSIZE-1:0] value;
	} int_item_t;

	// --------------------
	// result word
	// --------------------

	// relu view of the result payload
	typedef struct packed {
		logic [cfg_pkg::DSIZE-1:0] act_dst;
		logic [cfg_pkg::DSIZE-1:0] act_val;
	} nrn_act_t;

	// same 32 bits read as a spike address or as destination plus activation
	typedef union packed {
		logic [cfg_pkg::AER_W-1:0] aer;
		nrn_act_t                  act;
	} nrn_res_u;

	typedef struct packed {
		logic       fired;
		nurn_type_e ntype;
		nrn_res_u   payload;
	} nrn_res_t;

endpackage

`default_nettype wire

// File: logic/potential_mem.sv
`timescale 1ns/1ps
`default_nettype none

module potential_mem #(
	parameter int unsigned NUM_NURNS = 256
) (
	input  wire logic                      clk_i,
	// host configuration write loads rst_pot
	input  wire logic                      cfg_we_i,
	input  wire cfg_pkg::cfg_wr_t          cfg_wr_i,
	// stage 2 read
	input  wire logic                      rd_en_i,
	input  wire logic [cfg_pkg::IDX_W-1:0] rd_idx_i,
	output logic      [cfg_pkg::DSIZE-1:0] pot_o,
	// stage 4 write-back
	input  wire logic                      wb_en_i,
	input  wire logic [cfg_pkg::IDX_W-1:0] wb_idx_i,
	input  wire logic [cfg_pkg::DSIZE-1:0] wb_pot_i
);
	import cfg_pkg::*;

	// unsigned membrane potential per neuron
	logic [DSIZE-1:0] pot_mem [NUM_NURNS];

	// config writes happen only while idle
	// so they never meet a write-back on the same edge
	always_ff @(posedge clk_i) begin
		if (cfg_we_i) begin
			pot_mem[cfg_wr_i.idx] <= cfg_wr_i.cfg.rst_pot;
		end else if (wb_en_i) begin
			pot_mem[wb_idx_i] <= wb_pot_i;
		end
	end

	// read lines up with the config word from config_mem
	always_ff @(posedge clk_i) begin
		if (rd_en_i) begin
			pot_o <= pot_mem[rd_idx_i];
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# compile the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_nrn_core -f build.f --Mdir obj_dir

# the simulation exits nonzero on failure, the log decides
./obj_dir/Vtb_nrn_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: tb/tb_nrn_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nrn_core;
	import cfg_pkg::*;
	import nrn_pkg::*;

	// 100 ns clock
	localparam int CLK_HALF = 50;
	// edges allowed for ack to rise or fall
	localparam int ACK_LIMIT = 20;
	// upper bound on the requests over all tests
	localparam int NUM_REQS = 60;
	// cycles for reset and configuration writes
	localparam int SETUP_CYCLES = 200;
	localparam int WATCHDOG_NS = (NUM_REQS * ACK_LIMIT + SETUP_CYCLES) * 2 * CLK_HALF;
	// seeds and taps for the DUT threshold lfsr and the stimulus lfsr
	localparam logic [DSIZE-1:0] DUT_SEED = 16'hACE1;
	localparam logic [DSIZE-1:0] GALOIS_TAPS = 16'hB400;
	localparam logic [DSIZE-1:0] STIM_SEED = 16'd13;

	logic clk_i;
	logic rst_n_i;
	logic cfg_we_i;
	cfg_wr_t cfg_wr_i;
	logic req_i;
	nrn_req_t req_data_i;
	logic ack_o;
	nrn_res_t res_o;

	// shadow state of the reference model
	nrn_cfg_t cfg_sh [256];
	logic [DSIZE-1:0] pot_sh [256];
	logic [DSIZE-1:0] model_lfsr;
	logic [DSIZE-1:0] stim_lfsr;

	nrn_core_top nrn_core_top_inst (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.cfg_we_i   (cfg_we_i),
		.cfg_wr_i   (cfg_wr_i),
		.req_i      (req_i),
		.req_data_i (req_data_i),
		.ack_o      (ack_o),
		.res_o      (res_o)
	);

	always #(CLK_HALF) clk_i = ~clk_i;

	// --------------------
	// helpers
	// --------------------

	// one right shift of a galois lfsr
	// taps folded in when bit 0 falls out
	function automatic logic [DSIZE-1:0] galois_step(input logic [DSIZE-1:0] s);
		return {1'b0, s[DSIZE-1:1]} ^ (s[0] ? GALOIS_TAPS : 16'h0000);
	endfunction

	function automatic nrn_cfg_t make_cfg(input logic ntype, input logic rnd,
			input logic [DSIZE-1:0] mask, input logic [DSIZE-1:0] rst,
			input logic [AER_W-1:0] aer);
		nrn_cfg_t c;
		c.nurn_type = ntype;
		c.rand_th = rnd;
		c.th_mask = mask;
		c.rst_pot = rst;
		c.spike_aer = aer;
		return c;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check(input string name, input logic [63:0] expd,
			input logic [63:0] act);
		if (expd !== act) begin
			abort_run($sformatf("FAILED %s: expected %0h, actual %0h",
				name, expd, act));
		end
	endtask

	// each bit taken costs one lfsr step
	task automatic draw_bits(input int nbits, output logic [DSIZE-1:0] val);
		int i;
		val = '0;
		for (i = 0; i < nbits; i++) begin
			stim_lfsr = galois_step(stim_lfsr);
			val = {val[DSIZE-2:0], stim_lfsr[0]};
		end
	endtask

	// config write also loads the potential with rst_pot
	task automatic write_cfg(input logic [IDX_W-1:0] idx, input nrn_cfg_t cfg);
		@(negedge clk_i);
		cfg_we_i = 1'b1;
		cfg_wr_i.idx = idx;
		cfg_wr_i.cfg = cfg;
		@(negedge clk_i);
		cfg_we_i = 1'b0;
		cfg_sh[idx] = cfg;
		pot_sh[idx] = cfg.rst_pot;
	endtask

	// expected result of one request
	// also moves the shadow potential and the threshold lfsr on
	task automatic model_request(input logic [IDX_W-1:0] idx,
			input logic signed [DSIZE-1:0] cur, output nrn_res_t expd);
		nrn_cfg_t c;
		int sum;
		logic [DSIZE-1:0] val;
		logic [DSIZE-1:0] thr;
		c = cfg_sh[idx];
		expd = '0;
		expd.ntype = nurn_type_e'(c.nurn_type);
		if (c.nurn_type == 1'b1) begin
			// relu keeps no state
			val = (cur > 0) ? 16'(cur) : 16'd0;
			expd.fired = (val != 16'd0);
			expd.payload.act.act_dst = c.spike_aer[AER_W-1:AER_W-DSIZE];
			expd.payload.act.act_val = val;
		end else begin
			sum = int'(pot_sh[idx]) + int'(cur);
			if (sum < 0) begin
				val = 16'd0;
			end else if (sum > 65535) begin
				val = 16'hFFFF;
			end else begin
				val = 16'(sum);
			end
			thr = c.rand_th ? (c.th_mask & model_lfsr) : c.th_mask;
			if (val >= thr) begin
				expd.fired = 1'b1;
				expd.payload.aer = c.spike_aer;
				pot_sh[idx] = c.rst_pot;
			end else begin
				pot_sh[idx] = val;
			end
		end
		// the DUT lfsr steps for every item, relu too
		model_lfsr = galois_step(model_lfsr);
	endtask

	// full four-phase transfer checked against the model
	task automatic do_request(input string name, input logic [IDX_W-1:0] idx,
			input logic signed [DSIZE-1:0] cur, input int hold, output nrn_res_t res);
		nrn_res_t expd;
		int edges;
		model_request(idx, cur, expd);
		@(negedge clk_i);
		req_data_i.idx = idx;
		req_data_i.in_cur = cur;
		req_i = 1'b1;
		edges = 0;
		while (!ack_o && edges < ACK_LIMIT) begin
			@(negedge clk_i);
			edges++;
		end
		if (!ack_o) begin
			abort_run($sformatf("%s: ack never rose after the request", name));
		end
		// first counted edge samples req, four more carry it through the pipeline
		check({name, " ack latency"}, 64'(4), 64'(edges - 1));
		res = res_o;
		check({name, " result"}, 64'(expd), 64'(res));
		// ack and result stay frozen while req is held
		repeat (hold) begin
			@(negedge clk_i);
			check({name, " ack held"}, 64'(1), 64'(ack_o));
			check({name, " result held"}, 64'(res), 64'(res_o));
		end
		req_i = 1'b0;
		edges = 0;
		while (ack_o && edges < ACK_LIMIT) begin
			@(negedge clk_i);
			edges++;
		end
		if (ack_o) begin
			abort_run($sformatf("%s: ack stayed high after req dropped", name));
		end
		check({name, " ack release"}, 64'(1), 64'(edges));
	endtask

	// --------------------
	// tests
	// --------------------

	task automatic test_handshake;
		nrn_res_t r;
		check("handshake ack after reset", 64'(0), 64'(ack_o));
		check("handshake result after reset", 64'(0), 64'(res_o));
		// 5 then 10 crosses the threshold of 8
		write_cfg(8'd1, make_cfg(1'b0, 1'b0, 16'd8, 16'd0, 32'h1111_0001));
		do_request("handshake setup", 8'd1, 16'sd5, 0, r);
		check("handshake setup fired", 64'(0), 64'(r.fired));
		// held result is a spike and a second launch from 0 would not fire
		do_request("handshake", 8'd1, 16'sd5, 5, r);
		check("handshake fired", 64'(1), 64'(r.fired));
	endtask

	task automatic test_if_accumulate;
		nrn_res_t r;
		write_cfg(8'd2, make_cfg(1'b0, 1'b0, 16'd1000, 16'd0, 32'hCAFE_0002));
		do_request("accumulate 1", 8'd2, 16'sd400, 0, r);
		check("accumulate 1 fired", 64'(0), 64'(r.fired));
		do_request("accumulate 2", 8'd2, 16'sd400, 0, r);
		check("accumulate 2 fired", 64'(0), 64'(r.fired));
		// 1200 crosses 1000
		do_request("accumulate 3", 8'd2, 16'sd400, 0, r);
		check("accumulate 3 fired", 64'(1), 64'(r.fired));
		check("accumulate 3 aer", 64'(32'hCAFE_0002), 64'(r.payload.aer));
		do_request("accumulate 4", 8'd2, 16'sd400, 0, r);
		check("accumulate 4 fired", 64'(0), 64'(r.fired));
	endtask

	task automatic test_if_saturate;
		nrn_res_t r;
		write_cfg(8'd3, make_cfg(1'b0, 1'b0, 16'hFFFF, 16'd100, 32'h5A7E_0003));
		// 100 - 500 clamps at zero
		do_request("saturate low", 8'd3, -16'sd500, 0, r);
		check("saturate low fired", 64'(0), 64'(r.fired));
		do_request("saturate small", 8'd3, 16'sd50, 0, r);
		check("saturate small fired", 64'(0), 64'(r.fired));
		do_request("saturate mid", 8'd3, 16'sd32767, 0, r);
		check("saturate mid fired", 64'(0), 64'(r.fired));
		// 65584 clamps to 65535 and meets the mask
		do_request("saturate high", 8'd3, 16'sd32767, 0, r);
		check("saturate high fired", 64'(1), 64'(r.fired));
		check("saturate high aer", 64'(32'h5A7E_0003), 64'(r.payload.aer));
	endtask

	task automatic test_relu;
		nrn_res_t r;
		write_cfg(8'd4, make_cfg(1'b1, 1'b0, 16'd0, 16'd0, 32'hBEEF_0004));
		do_request("relu negative", 8'd4, -16'sd300, 0, r);
		check("relu negative fired", 64'(0), 64'(r.fired));
		check("relu negative act_val", 64'(0), 64'(r.payload.act.act_val));
		do_request("relu positive", 8'd4, 16'sd1234, 0, r);
		check("relu positive fired", 64'(1), 64'(r.fired));
		check("relu positive type", 64'(NT_RELU), 64'(r.ntype));
		check("relu positive act_val", 64'(1234), 64'(r.payload.act.act_val));
		check("relu positive act_dst", 64'(16'hBEEF), 64'(r.payload.act.act_dst));
		// neuron 2 holds 400 and goes to 800
		do_request("relu then if", 8'd2, 16'sd400, 0, r);
		check("relu then if fired", 64'(0), 64'(r.fired));
	endtask

	task automatic test_rand_threshold;
		nrn_res_t r;
		logic [DSIZE-1:0] b;
		logic [IDX_W-1:0] idx;
		logic signed [DSIZE-1:0] cur;
		int k;
		// neurons 8..15 with every fourth one relu
		for (k = 0; k < 8; k++) begin
			if (k % 4 == 3) begin
				write_cfg(8'(8 + k),
					make_cfg(1'b1, 1'b0, 16'd0, 16'd0, 32'(32'h7700_0000 + k)));
			end else begin
				write_cfg(8'(8 + k),
					make_cfg(1'b0, 1'b1, 16'h03FF, 16'd0, 32'(32'hF00D_0000 + k)));
			end
		end
		for (k = 0; k < 40; k++) begin
			draw_bits(3, b);
			idx = 8'(b[2:0]) + 8'd8;
			// currents from -300 to 723
			draw_bits(10, b);
			cur = b - 16'd300;
			do_request($sformatf("rand threshold %0d", k), idx, cur, 0, r);
		end
	endtask

	task automatic test_reconfigure;
		nrn_res_t r;
		// neuron 3 reloads to 900 so 150 fires against 1000
		write_cfg(8'd3, make_cfg(1'b0, 1'b0, 16'd1000, 16'd900, 32'h3333_0003));
		do_request("reconfigure if", 8'd3, 16'sd150, 0, r);
		check("reconfigure if fired", 64'(1), 64'(r.fired));
		// neuron 2 turns from i&f into relu
		write_cfg(8'd2, make_cfg(1'b1, 1'b0, 16'd0, 16'd77, 32'h2222_0002));
		do_request("reconfigure relu neg", 8'd2, -16'sd5, 0, r);
		check("reconfigure relu type", 64'(NT_RELU), 64'(r.ntype));
		check("reconfigure relu neg fired", 64'(0), 64'(r.fired));
		do_request("reconfigure relu pos", 8'd2, 16'sd60, 0, r);
		check("reconfigure relu pos act_val", 64'(60), 64'(r.payload.act.act_val));
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		cfg_we_i = 1'b0;
		cfg_wr_i = '0;
		req_i = 1'b0;
		req_data_i = '0;
		model_lfsr = DUT_SEED;
		stim_lfsr = STIM_SEED;
		repeat (3) @(negedge clk_i);
		rst_n_i = 1'b1;
		test_handshake();
		test_if_accumulate();
		test_if_saturate();
		test_relu();
		test_rand_threshold();
		test_reconfigure();
		$display("TEST OK");
		$finish;
	end

	// watchdog sized from the request count
	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire
